//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_arith_unit
FLIST      = all.f
BUILD      = obj_dir
LOG        = sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD) -o V$(TOP)

# pass or fail comes from the log, not from the exit status of the binary.
sim: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
verilog/arith_pkg.sv
verilog/op_pkg.sv
verilog/div_if.sv
verilog/barrel_rotator.sv
verilog/gs_divider.sv
verilog/op_ctrl.sv
verilog/arith_unit.sv
verification/tb_clock.sv
verification/tb_arith_unit.sv

//--- verification/tb_arith_unit.sv
`timescale 1ns/1ns
// arithmetic unit testbench
module tb_arith_unit import arith_pkg::*, op_pkg::*; ();

    localparam int num_ops     = 2000;
    localparam int cycle_limit = num_ops * 16 + 100;
    localparam int rdy_limit   = 20;

    logic       clk;
    logic       rst;
    logic       start;
    logic [1:0] op;
    word_t      a;
    word_t      b;
    word_t      result;
    word_t      remainder;
    logic       dz;
    logic       bsy;
    logic       rdy;

    integer seed         = 75498;
    int     checks       = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    int     cycles       = 0;

    // model copy of the outputs after the last rdy.
    word_t last_result    = '0;
    word_t last_remainder = '0;
    logic  last_dz        = 1'b0;

    tb_clock i_tb_clock (
        .clk (clk),
        .rst (rst)
    );

    arith_unit i_arith_unit (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op        (op),
        .a         (a),
        .b         (b),
        .result    (result),
        .remainder (remainder),
        .dz        (dz),
        .bsy       (bsy),
        .rdy       (rdy)
    );

    function automatic word_t rotate_left(input word_t w, input shamt_t n);
        logic [2*word_w-1:0] t;
        t = {w, w} << n;
        return t[2*word_w-1:word_w];
    endfunction

    function automatic word_t rotate_right(input word_t w, input shamt_t n);
        logic [2*word_w-1:0] t;
        t = {w, w} >> n;
        return t[word_w-1:0];
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // outputs must keep the last result, with no rdy and no busy.
    task automatic hold_check(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value("rdy", word_t'(0), word_t'(rdy));
            check_value("bsy", word_t'(0), word_t'(bsy));
            check_value("result", last_result, result);
            check_value("remainder", last_remainder, remainder);
            check_value("dz", word_t'(last_dz), word_t'(dz));
        end
    endtask

    task automatic bad_start(input word_t av, input word_t bv);
        @(posedge clk);
        start <= 1'b1;
        op    <= OP_BAD;
        a     <= av;
        b     <= bv;
        @(posedge clk);
        start <= 1'b0;
        hold_check(4);
    endtask

    task automatic run_op(input logic [1:0] code, input word_t av, input word_t bv,
                          input logic poke);
        word_t exp_res;
        word_t exp_rem;
        logic  exp_dz;
        int    lat;
        logic  got;
        case (code)
            OP_ROL: begin
                exp_res = rotate_left(av, bv[shamt_w-1:0]);
                exp_rem = '0;
                exp_dz  = 1'b0;
            end
            OP_ROR: begin
                exp_res = rotate_right(av, bv[shamt_w-1:0]);
                exp_rem = '0;
                exp_dz  = 1'b0;
            end
            default: begin
                if (bv == '0) begin
                    exp_res = '1;
                    exp_rem = av;
                    exp_dz  = 1'b1;
                end else begin
                    exp_res = av / bv;
                    exp_rem = av % bv;
                    exp_dz  = 1'b0;
                end
            end
        endcase
        @(posedge clk);
        start <= 1'b1;
        op    <= code;
        a     <= av;
        b     <= bv;
        @(posedge clk);
        start <= 1'b0;
        // lat counts clocks after the accepting edge.
        lat = 0;
        @(negedge clk);
        got = rdy;
        while (!got && lat < rdy_limit) begin
            check_value("bsy", word_t'(1), word_t'(bsy));
            @(posedge clk);
            lat = lat + 1;
            if (poke && lat == 3) begin
                start <= 1'b1;
                op    <= 2'($random(seed));
                a     <= word_t'($random(seed));
                b     <= word_t'($random(seed));
            end else if (poke && lat == 4) begin
                start <= 1'b0;
            end
            @(negedge clk);
            got = rdy;
        end
        if (!got) begin
            $display("no rdy within %0d clocks of a start with opcode %0d", rdy_limit, code);
            other_errors++;
        end else begin
            if (code == OP_DIV && bv != '0) begin
                if (lat < 9 || lat > 12) begin
                    $display("division rdy after %0d clocks, outside 9 to 12", lat);
                    other_errors++;
                end
            end else if (code != OP_DIV) begin
                check_value("rotate latency", word_t'(1), word_t'(lat));
            end
            check_value("result", exp_res, result);
            check_value("remainder", exp_rem, remainder);
            check_value("dz", word_t'(exp_dz), word_t'(dz));
            check_value("bsy", word_t'(0), word_t'(bsy));
        end
        last_result    = exp_res;
        last_remainder = exp_rem;
        last_dz        = exp_dz;
        if (poke) begin
            hold_check(3);
        end
    endtask

    initial begin : main_flow
        logic [1:0] code;
        word_t      av;
        word_t      bv;
        logic [2:0] sel;
        logic       poke;
        start = 1'b0;
        op    = 2'b00;
        a     = '0;
        b     = '0;
        wait (rst === 1'b1);
        hold_check(2);
        for (int n = 0; n < num_ops; n++) begin
            code = 2'($random(seed));
            av   = word_t'($random(seed));
            bv   = word_t'($random(seed));
            sel  = 3'($random(seed));
            if (3'($random(seed)) == 3'd0) begin
                av = '0;
            end
            // zero, small and power of two divisors, edge rotate amounts.
            if (code == OP_DIV) begin
                case (sel)
                    3'd0: bv = '0;
                    3'd1: bv = {28'd0, bv[3:0]};
                    3'd2: bv = word_t'(1) << bv[shamt_w-1:0];
                    default: ;
                endcase
            end else begin
                case (sel)
                    3'd0: bv[shamt_w-1:0] = '0;
                    3'd1: bv[shamt_w-1:0] = '1;
                    default: ;
                endcase
            end
            poke = (code == OP_DIV) && (bv != '0) && (2'($random(seed)) == 2'd0);
            if (code == OP_BAD) begin
                bad_start(av, bv);
            end else begin
                run_op(code, av, bv, poke);
            end
        end
        finish_run();
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
            other_errors++;
            finish_run();
        end
    end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/1ns
// testbench clock and reset
module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // low for three full periods, released on a falling edge.
    initial begin
        rst = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

//--- verilog/arith_pkg.sv
// arithmetic datapath definitions
package arith_pkg;

    // operand and result words.
    localparam int word_w  = 32;
    localparam int shamt_w = 5;

    typedef logic [word_w-1:0]  word_t;
    typedef logic [shamt_w-1:0] shamt_t;

    // goldschmidt registers, one integer bit above 63 fraction bits.
    localparam int fix_w = 64;

    typedef logic [fix_w-1:0] fix_t;

    // error squares each pass, five passes reach 2^-32.
    localparam int gs_iters = 5;

endpackage

//--- verilog/arith_unit.sv
`timescale 1ns/1ns
// rotate and divide unit
module arith_unit import arith_pkg::*, op_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [1:0]  op,
    input  word_t       a,
    input  word_t       b,
    output word_t       result,
    output word_t       remainder,
    output logic        dz,
    output logic        bsy,
    output logic        rdy
);

    word_t  rot_word;
    shamt_t rot_amount;
    logic   rot_left;
    word_t  rotated;

    div_if i_div_if ();

    op_ctrl i_op_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op_t'(op)),
        .a          (a),
        .b          (b),
        .rotated    (rotated),
        .rot_word   (rot_word),
        .rot_amount (rot_amount),
        .rot_left   (rot_left),
        .dv         (i_div_if.ctrl),
        .result     (result),
        .remainder  (remainder),
        .dz         (dz),
        .bsy        (bsy),
        .rdy        (rdy)
    );

    barrel_rotator i_barrel_rotator (
        .word    (rot_word),
        .amount  (rot_amount),
        .left    (rot_left),
        .rotated (rotated)
    );

    gs_divider i_gs_divider (
        .clk (clk),
        .rst (rst),
        .dv  (i_div_if.div)
    );

endmodule

//--- verilog/barrel_rotator.sv
`timescale 1ns/1ns
// word rotator
module barrel_rotator import arith_pkg::*; (
    input  word_t  word,
    input  shamt_t amount,
    input  logic   left,
    output word_t  rotated
);

    shamt_t amt_eff;
    word_t  stage [shamt_w+1];

    // right by n is left by 32 - n.
    assign amt_eff = left ? amount : (~amount + shamt_t'(1));

    assign stage[0] = word;

    // one mux level per amount bit, steps of 1, 2, 4, 8 and 16.
    for (genvar i = 0; i < shamt_w; i++) begin : g_stage
        assign stage[i+1] = amt_eff[i]
            ? ((stage[i] << (1 << i)) | (stage[i] >> (word_w - (1 << i))))
            : stage[i];
    end

    assign rotated = stage[shamt_w];

endmodule

//--- verilog/div_if.sv
`timescale 1ns/1ns
// division request and result
interface div_if import arith_pkg::*; ();

    logic  req;
    word_t dividend;
    word_t divisor;

    word_t quotient;
    word_t rem;
    logic  dz;
    logic  done;

    modport ctrl (
        output req, dividend, divisor,
        input  quotient, rem, dz, done
    );

    // results stay put from done until the next req.
    modport div (
        input  req, dividend, divisor,
        output quotient, rem, dz, done
    );

endinterface

//--- verilog/gs_divider.sv
`timescale 1ns/1ns
// goldschmidt divider
module gs_divider import arith_pkg::*, op_pkg::*; (
    input logic clk,
    input logic rst,
    div_if.div  dv
);

    div_state_t state;
    logic [$clog2(gs_iters)-1:0] it_cnt;
    logic fix_step;

    word_t  dividend_q;
    word_t  divisor_q;
    shamt_t lz_q;
    fix_t   n_est;
    fix_t   d_est;
    logic [word_w:0] q_est;

    shamt_t lz_now;
    word_t  d_norm;
    fix_t   factor;
    logic [2*fix_w-1:0] n_prod;
    logic [2*fix_w-1:0] d_prod;
    logic [fix_w:0] half_ulp;
    logic [fix_w:0] n_round;
    logic [fix_w:0] qd_prod;
    logic signed [fix_w+1:0] r_try;
    logic signed [fix_w+1:0] d_ext;

    function automatic shamt_t lead_zeros(input word_t v);
        shamt_t n;
        n = '0;
        for (int i = 0; i < word_w; i++) begin
            if (v[i]) begin
                n = shamt_t'(word_w - 1 - i);
            end
        end
        return n;
    endfunction

    assign lz_now = lead_zeros(divisor_q);
    assign d_norm = divisor_q << lz_now;

    // two minus the denominator, wraps to fit.
    assign factor = ~d_est + fix_t'(1);
    assign n_prod = n_est * factor;
    assign d_prod = d_est * factor;

    // quotient is n_est scaled by 2^lz, rounded to nearest.
    assign half_ulp = {1'b1, {fix_w{1'b0}}} >> (int'(lz_q) + 2);
    assign n_round  = ({1'b0, n_est} + half_ulp) >> (fix_w - 1 - int'(lz_q));

    // remainder of the estimate, may be negative or one divisor too big.
    assign qd_prod = q_est * divisor_q;
    assign d_ext   = $signed({{(fix_w+2-word_w){1'b0}}, divisor_q});
    assign r_try   = $signed({{(fix_w+2-word_w){1'b0}}, dividend_q})
                   - $signed({1'b0, qd_prod});

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= S_IDLE;
            it_cnt   <= '0;
            fix_step <= 1'b0;
            dv.done  <= 1'b0;
        end else begin
            dv.done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (dv.req) begin
                        state <= S_NORM;
                    end
                end
                S_NORM: begin
                    it_cnt <= '0;
                    if (divisor_q == '0) begin
                        state   <= S_DONE;
                        dv.done <= 1'b1;
                    end else begin
                        state <= S_ITER;
                    end
                end
                S_ITER: begin
                    it_cnt <= it_cnt + 1'b1;
                    if (int'(it_cnt) == gs_iters - 1) begin
                        state    <= S_FIX;
                        fix_step <= 1'b0;
                    end
                end
                S_FIX: begin
                    fix_step <= 1'b1;
                    if (fix_step) begin
                        state   <= S_DONE;
                        dv.done <= 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (dv.req) begin
                    dividend_q <= dv.dividend;
                    divisor_q  <= dv.divisor;
                end
            end
            S_NORM: begin
                // denominator lands in [0.5, 1).
                lz_q  <= lz_now;
                n_est <= {1'b0, dividend_q, {(fix_w-word_w-1){1'b0}}};
                d_est <= {1'b0, d_norm, {(fix_w-word_w-1){1'b0}}};
                dv.dz <= (divisor_q == '0);
                if (divisor_q == '0) begin
                    dv.quotient <= '1;
                    dv.rem      <= dividend_q;
                end
            end
            S_ITER: begin
                n_est <= n_prod[2*fix_w-2:fix_w-1];
                d_est <= d_prod[2*fix_w-2:fix_w-1];
            end
            S_FIX: begin
                if (!fix_step) begin
                    q_est <= n_round[word_w:0];
                end else if (r_try < 0) begin
                    dv.quotient <= word_t'(q_est - 1'b1);
                    dv.rem      <= word_t'(r_try + d_ext);
                end else if (r_try >= d_ext) begin
                    dv.quotient <= word_t'(q_est + 1'b1);
                    dv.rem      <= word_t'(r_try - d_ext);
                end else begin
                    dv.quotient <= word_t'(q_est);
                    dv.rem      <= word_t'(r_try);
                end
            end
            default: begin
            end
        endcase
    end

    // convergence keeps the denominator normalized.
    a_den_norm: assert property (@(posedge clk) disable iff (!rst)
        (state == S_ITER) |-> d_est[fix_w-2]);

    // a finished division leaves a remainder below the divisor.
    a_done_state: assert property (@(posedge clk) disable iff (!rst)
        dv.done |-> (state == S_DONE) && (dv.dz || (dv.rem < divisor_q)));

endmodule

//--- verilog/op_ctrl.sv
`timescale 1ns/1ns
// command register and result hold
module op_ctrl import arith_pkg::*, op_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  op_t    op,
    input  word_t  a,
    input  word_t  b,
    input  word_t  rotated,
    output word_t  rot_word,
    output shamt_t rot_amount,
    output logic   rot_left,
    div_if.ctrl    dv,
    output word_t  result,
    output word_t  remainder,
    output logic   dz,
    output logic   bsy,
    output logic   rdy
);

    op_t   op_q;
    word_t a_q;
    word_t b_q;
    logic  rot_pend;
    logic  div_out;
    logic  accept;

    // starts during busy, rdy or with a bad opcode are dropped.
    assign accept = start && !bsy && !rdy && (op != OP_BAD);

    assign rot_word    = a_q;
    assign rot_amount  = b_q[shamt_w-1:0];
    assign rot_left    = (op_q == OP_ROL);
    assign dv.dividend = a_q;
    assign dv.divisor  = b_q;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= op;
            a_q  <= a;
            b_q  <= b;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bsy       <= 1'b0;
            rdy       <= 1'b0;
            rot_pend  <= 1'b0;
            div_out   <= 1'b0;
            dv.req    <= 1'b0;
            result    <= '0;
            remainder <= '0;
            dz        <= 1'b0;
        end else begin
            rdy    <= 1'b0;
            dv.req <= 1'b0;
            if (accept) begin
                bsy <= 1'b1;
                if (op == OP_DIV) begin
                    dv.req <= 1'b1;
                end else begin
                    rot_pend <= 1'b1;
                end
            end
            if (dv.req) begin
                div_out <= 1'b1;
            end
            // rotator output is settled one cycle after capture.
            if (rot_pend) begin
                rot_pend  <= 1'b0;
                result    <= rotated;
                remainder <= '0;
                dz        <= 1'b0;
                rdy       <= 1'b1;
                bsy       <= 1'b0;
            end
            if (div_out && dv.done) begin
                div_out   <= 1'b0;
                result    <= dv.quotient;
                remainder <= dv.rem;
                dz        <= dv.dz;
                rdy       <= 1'b1;
                bsy       <= 1'b0;
            end
        end
    end

    a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst)
        rdy |=> !rdy);

    // one division in flight at a time.
    a_req_single: assert property (@(posedge clk) disable iff (!rst)
        dv.req |-> !div_out);

endmodule

//--- verilog/op_pkg.sv
// opcode and divider states
package op_pkg;

    // two-bit command opcode.
    typedef enum logic [1:0] {
        OP_ROL = 2'd0,
        OP_ROR = 2'd1,
        OP_DIV = 2'd2,
        OP_BAD = 2'd3
    } op_t;

    // divider sequencing.
    typedef enum logic [2:0] {
        S_IDLE,
        S_NORM,
        S_ITER,
        S_FIX,
        S_DONE
    } div_state_t;

endpackage
